// File: hdl/ps2_kbd_settings.svh
`ifndef PS2_KBD_SETTINGS_SVH
`define PS2_KBD_SETTINGS_SVH

// PS/2 frame is start, 8 data bits LSB first, odd parity, stop
`define PS2_FRAME_BITS 11

`define PS2_SYNC_STAGES 2   // Flops on each PS/2 input

// Set-2 prefix bytes
`define KBD_BREAK_CODE 8'hF0
`define KBD_EXT_CODE   8'hE0

`define SEG_BLANK 8'hFF     // All segments and dp off

`endif

// File: hdl/ps2_kbd_pkg.sv
package ps2_kbd_pkg;

    // One byte: scan code, ASCII code or press count
    typedef logic [7:0] scan_code_t;

    // Active-low segments {dp, g, f, e, d, c, b, a}
    typedef logic [7:0] seg_t;

    typedef enum logic [1:0] {
        st_make,    // Expecting a make code or a prefix
        st_break,   // F0 seen, next byte is the released key
        st_ext      // E0 seen, rest of the sequence is dropped
    } kbd_state_t;

endpackage

// File: hdl/ps2_rx.sv
`timescale 1ns/1ns
`include "ps2_kbd_settings.svh"

module ps2_rx import ps2_kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output scan_code_t scan_code,
    output logic       scan_valid,
    output logic       frame_err
);

    localparam int CNT_W = $clog2(`PS2_FRAME_BITS);
    localparam int SYNC_MSB = `PS2_SYNC_STAGES - 1;

    logic [SYNC_MSB:0]            clk_sync;
    logic [SYNC_MSB:0]            data_sync;
    logic                         clk_prev;
    logic                         clk_fall;
    logic [CNT_W-1:0]             bit_cnt;
    logic [`PS2_FRAME_BITS-1:0]   frame;
    logic [`PS2_FRAME_BITS-1:0]   frame_nxt;
    logic                         last_bit;
    logic                         frame_ok;

    // Both lines idle high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[SYNC_MSB-1:0], ps2_clk};
            data_sync <= {data_sync[SYNC_MSB-1:0], ps2_data};
            clk_prev  <= clk_sync[SYNC_MSB];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[SYNC_MSB];

    // Bits arrive LSB first, so the frame shifts right
    assign frame_nxt = {data_sync[SYNC_MSB], frame[`PS2_FRAME_BITS-1:1]};
    assign last_bit  = clk_fall && (bit_cnt == CNT_W'(`PS2_FRAME_BITS - 1));

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = !frame_nxt[0] && frame_nxt[`PS2_FRAME_BITS-1] &&
                      (^frame_nxt[`PS2_FRAME_BITS-2:1]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (clk_fall) begin
            bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            frame <= frame_nxt;
        end
        if (last_bit) begin
            scan_code <= frame_nxt[8:1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            scan_valid <= last_bit && frame_ok;
            frame_err  <= last_bit && !frame_ok;
        end
    end

    a_valid_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(scan_valid && frame_err));

    // Frames are hundreds of cycles apart, a strobe never stretches
    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        scan_valid |=> !scan_valid);

endmodule

// File: hdl/kbd_ctrl.sv
`timescale 1ns/1ns
`include "ps2_kbd_settings.svh"

module kbd_ctrl import ps2_kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  scan_code_t scan_code,
    input  logic       scan_valid,
    output scan_code_t key,
    output scan_code_t count,
    output logic       is_press
);

    kbd_state_t state;
    logic       new_press;

    // A repeat of the held key is typematic, not a new press
    assign new_press = !is_press || (scan_code != key);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_make;
            key      <= '0;
            count    <= '0;
            is_press <= 1'b0;
        end else if (scan_valid) begin
            case (state)
                st_make: begin
                    if (scan_code == `KBD_BREAK_CODE) begin
                        state <= st_break;
                    end else if (scan_code == `KBD_EXT_CODE) begin
                        state <= st_ext;
                    end else begin
                        key      <= scan_code;
                        is_press <= 1'b1;
                        if (new_press) begin
                            count <= count + 8'd1;   // Wraps at FF
                        end
                    end
                end
                st_break: begin
                    // Release of some other key leaves the held one shown
                    if (scan_code == key) begin
                        is_press <= 1'b0;
                    end
                    state <= st_make;
                end
                st_ext: begin
                    if (scan_code != `KBD_BREAK_CODE) begin
                        state <= st_make;   // F0 keeps swallowing
                    end
                end
                default: state <= st_make;
            endcase
        end
    end

    a_count_on_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !scan_valid |=> $stable(count));

endmodule

// File: hdl/key2ascii.sv
`timescale 1ns/1ns

module key2ascii import ps2_kbd_pkg::*; (
    input  scan_code_t key,
    output scan_code_t ascii
);

    // Set-2 make codes, unshifted only
    always_comb begin
        case (key)
            8'h1C: ascii = 8'h61;   // a
            8'h32: ascii = 8'h62;
            8'h21: ascii = 8'h63;
            8'h23: ascii = 8'h64;
            8'h24: ascii = 8'h65;
            8'h2B: ascii = 8'h66;
            8'h34: ascii = 8'h67;
            8'h33: ascii = 8'h68;
            8'h43: ascii = 8'h69;
            8'h3B: ascii = 8'h6A;
            8'h42: ascii = 8'h6B;
            8'h4B: ascii = 8'h6C;
            8'h3A: ascii = 8'h6D;
            8'h31: ascii = 8'h6E;
            8'h44: ascii = 8'h6F;
            8'h4D: ascii = 8'h70;
            8'h15: ascii = 8'h71;
            8'h2D: ascii = 8'h72;
            8'h1B: ascii = 8'h73;
            8'h2C: ascii = 8'h74;
            8'h3C: ascii = 8'h75;
            8'h2A: ascii = 8'h76;
            8'h1D: ascii = 8'h77;
            8'h22: ascii = 8'h78;
            8'h35: ascii = 8'h79;
            8'h1A: ascii = 8'h7A;   // z
            // Top-row digits
            8'h45: ascii = 8'h30;
            8'h16: ascii = 8'h31;
            8'h1E: ascii = 8'h32;
            8'h26: ascii = 8'h33;
            8'h25: ascii = 8'h34;
            8'h2E: ascii = 8'h35;
            8'h36: ascii = 8'h36;
            8'h3D: ascii = 8'h37;
            8'h3E: ascii = 8'h38;
            8'h46: ascii = 8'h39;
            8'h29: ascii = 8'h20;   // Space
            8'h5A: ascii = 8'h0D;   // Enter
            default: ascii = 8'h00;
        endcase
    end

endmodule

// File: hdl/hex7seg.sv
`timescale 1ns/1ns

module hex7seg import ps2_kbd_pkg::*; (
    input  logic [3:0] digit,
    output seg_t       seg
);

    // Active low, gfedcba in bits 6..0, dp (bit 7) always off
    always_comb begin
        case (digit)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83;
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1;
            4'hE: seg = 8'h86;
            default: seg = 8'h8E;   // F
        endcase
    end

endmodule

// File: hdl/kbd_display_top.sv
`timescale 1ns/1ns
`include "ps2_kbd_settings.svh"

module kbd_display_top import ps2_kbd_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic ps2_clk,
    input  logic ps2_data,
    output seg_t key_lo_seg,
    output seg_t key_hi_seg,
    output seg_t ascii_lo_seg,
    output seg_t ascii_hi_seg,
    output seg_t count_lo_seg,
    output seg_t count_hi_seg,
    output logic is_press,
    output logic frame_err
);

    localparam seg_t SEG_ZERO = 8'hC0;   // Count shows "00" out of reset

    scan_code_t scan_code;
    logic       scan_valid;
    scan_code_t key;
    scan_code_t count;
    scan_code_t ascii;
    seg_t       key_lo_nxt;
    seg_t       key_hi_nxt;
    seg_t       ascii_lo_nxt;
    seg_t       ascii_hi_nxt;
    seg_t       count_lo_nxt;
    seg_t       count_hi_nxt;

    ps2_rx u_ps2_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .frame_err  (frame_err)
    );

    kbd_ctrl u_kbd_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .key        (key),
        .count      (count),
        .is_press   (is_press)
    );

    key2ascii u_key2ascii (.key(key), .ascii(ascii));

    hex7seg u_key_lo   (.digit(key[3:0]),   .seg(key_lo_nxt));
    hex7seg u_key_hi   (.digit(key[7:4]),   .seg(key_hi_nxt));
    hex7seg u_ascii_lo (.digit(ascii[3:0]), .seg(ascii_lo_nxt));
    hex7seg u_ascii_hi (.digit(ascii[7:4]), .seg(ascii_hi_nxt));
    hex7seg u_count_lo (.digit(count[3:0]), .seg(count_lo_nxt));
    hex7seg u_count_hi (.digit(count[7:4]), .seg(count_hi_nxt));

    // Key and ASCII digits go dark once the key is released
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_lo_seg   <= `SEG_BLANK;
            key_hi_seg   <= `SEG_BLANK;
            ascii_lo_seg <= `SEG_BLANK;
            ascii_hi_seg <= `SEG_BLANK;
            count_lo_seg <= SEG_ZERO;
            count_hi_seg <= SEG_ZERO;
        end else begin
            key_lo_seg   <= is_press ? key_lo_nxt   : `SEG_BLANK;
            key_hi_seg   <= is_press ? key_hi_nxt   : `SEG_BLANK;
            ascii_lo_seg <= is_press ? ascii_lo_nxt : `SEG_BLANK;
            ascii_hi_seg <= is_press ? ascii_hi_nxt : `SEG_BLANK;
            count_lo_seg <= count_lo_nxt;
            count_hi_seg <= count_hi_nxt;
        end
    end

endmodule

// File: dv/tb_kbd_display.sv
`timescale 1ns/1ns
`include "ps2_kbd_settings.svh"

module tb_kbd_display import ps2_kbd_pkg::*; ();

    localparam int HALF_BIT     = 20;   // clk cycles per PS/2 clock phase
    localparam int FRAME_CYCLES = `PS2_FRAME_BITS * 2 * HALF_BIT + 10;
    localparam int N_FRAMES     = 64;   // Frames sent over all tests
    localparam int MAX_CYCLES   = N_FRAMES * FRAME_CYCLES + 2000;

    logic clk;
    logic rst_n;
    logic ps2_clk;
    logic ps2_data;
    seg_t key_lo_seg;
    seg_t key_hi_seg;
    seg_t ascii_lo_seg;
    seg_t ascii_hi_seg;
    seg_t count_lo_seg;
    seg_t count_hi_seg;
    logic is_press;
    logic frame_err;

    int errors;
    int tests;
    int failed_tests;
    int err_pulses;
    int cycles;

    // Reference model of the controller
    scan_code_t key_m;
    scan_code_t count_m;
    logic       press_m;
    int         mstate;   // 0 make, 1 after F0, 2 after E0

    seg_t seg_tab [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                           8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
    // Set-2 codes for a to z, then 0 to 9
    scan_code_t letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
                                      8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31,
                                      8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C,
                                      8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    scan_code_t digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
                                     8'h3D, 8'h3E, 8'h46};

    kbd_display_top u_kbd_display_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_lo_seg   (key_lo_seg),
        .key_hi_seg   (key_hi_seg),
        .ascii_lo_seg (ascii_lo_seg),
        .ascii_hi_seg (ascii_hi_seg),
        .count_lo_seg (count_lo_seg),
        .count_hi_seg (count_hi_seg),
        .is_press     (is_press),
        .frame_err    (frame_err)
    );

    always #2 clk = ~clk;

    // Pulse watch on frame_err plus the cycle limit
    always @(posedge clk) begin
        if (frame_err === 1'b1) begin
            err_pulses++;
        end
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic scan_code_t ascii_of(scan_code_t code);
        scan_code_t a;
        a = 8'h00;
        for (int i = 0; i < 26; i++) begin
            if (letter_codes[i] == code) a = 8'h61 + 8'(i);
        end
        for (int i = 0; i < 10; i++) begin
            if (digit_codes[i] == code) a = 8'h30 + 8'(i);
        end
        if (code == 8'h29) a = 8'h20;
        if (code == 8'h5A) a = 8'h0D;
        return a;
    endfunction

    task automatic model_byte(scan_code_t b);
        case (mstate)
            0: begin
                if (b == `KBD_BREAK_CODE) mstate = 1;
                else if (b == `KBD_EXT_CODE) mstate = 2;
                else begin
                    if (!press_m || b != key_m) count_m = count_m + 8'd1;
                    key_m   = b;
                    press_m = 1'b1;
                end
            end
            1: begin
                if (b == key_m) press_m = 1'b0;
                mstate = 0;
            end
            default: if (b != `KBD_BREAK_CODE) mstate = 0;   // E0 F0 xx is swallowed whole
        endcase
    endtask

    // Frame goes out LSB first with data changing while ps2_clk is high
    task automatic ps2_send_byte(scan_code_t b, bit bad_parity);
        logic [`PS2_FRAME_BITS-1:0] frame;
        frame = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            ps2_data <= frame[i];
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        repeat (10) @(posedge clk);
    endtask

    task automatic send_code(scan_code_t b);
        ps2_send_byte(b, 1'b0);
        model_byte(b);
    endtask

    task automatic check_seg(string name, seg_t got, seg_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expect_display();
        scan_code_t asc;
        asc = ascii_of(key_m);
        check_bit("is_press", is_press, press_m);
        check_seg("key_lo_seg", key_lo_seg, press_m ? seg_tab[key_m[3:0]] : `SEG_BLANK);
        check_seg("key_hi_seg", key_hi_seg, press_m ? seg_tab[key_m[7:4]] : `SEG_BLANK);
        check_seg("ascii_lo_seg", ascii_lo_seg, press_m ? seg_tab[asc[3:0]] : `SEG_BLANK);
        check_seg("ascii_hi_seg", ascii_hi_seg, press_m ? seg_tab[asc[7:4]] : `SEG_BLANK);
        check_seg("count_lo_seg", count_lo_seg, seg_tab[count_m[3:0]]);
        check_seg("count_hi_seg", count_hi_seg, seg_tab[count_m[7:4]]);
    endtask

    task automatic finish_test(string name, int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic press_release(scan_code_t k);
        send_code(k);
        expect_display();
        send_code(`KBD_BREAK_CODE);
        send_code(k);
        expect_display();
    endtask

    initial begin
        int         e;
        int         idx;
        int         pulses0;
        scan_code_t k;
        scan_code_t cnt0;
        clk      = 1'b0;
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        key_m    = 8'h00;
        count_m  = 8'h00;
        press_m  = 1'b0;
        mstate   = 0;
        void'($urandom(32'h4f075e0b));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        e = errors;
        expect_display();
        check_seg("count_lo_seg", count_lo_seg, 8'hC0);
        finish_test("reset state", e);

        e = errors;
        send_code(8'h1C);
        expect_display();
        check_seg("ascii_hi_seg", ascii_hi_seg, seg_tab[6]);
        check_seg("count_lo_seg", count_lo_seg, seg_tab[1]);
        send_code(`KBD_BREAK_CODE);
        send_code(8'h1C);
        expect_display();
        finish_test("press and release", e);

        e = errors;
        send_code(8'h1B);
        cnt0 = count_m;
        send_code(8'h1B);   // Typematic repeat
        check_seg("count_lo_seg", count_lo_seg, seg_tab[cnt0[3:0]]);
        send_code(`KBD_BREAK_CODE);
        send_code(8'h1B);
        cnt0 = count_m;
        for (int n = 0; n < 12; n++) begin
            idx = int'($urandom % 36);
            k = (idx < 26) ? letter_codes[idx] : digit_codes[idx - 26];
            press_release(k);
        end
        cnt0 = cnt0 + 8'd12;
        check_seg("count_lo_seg", count_lo_seg, seg_tab[cnt0[3:0]]);
        check_seg("count_hi_seg", count_hi_seg, seg_tab[cnt0[7:4]]);
        press_release(8'h29);   // Space
        press_release(8'h5A);   // Enter
        send_code(8'h76);   // Esc has no ASCII entry
        expect_display();
        check_seg("ascii_lo_seg", ascii_lo_seg, 8'hC0);
        send_code(`KBD_BREAK_CODE);
        send_code(8'h76);
        finish_test("press counting", e);

        e = errors;
        send_code(8'h2B);
        pulses0 = err_pulses;
        ps2_send_byte(8'h1C, 1'b1);
        if (err_pulses != pulses0 + 1) begin
            errors++;
            $display("frame_err pulsed %0d times for one bad-parity frame instead of once",
                     err_pulses - pulses0);
        end
        expect_display();
        send_code(`KBD_BREAK_CODE);
        send_code(8'h2B);
        finish_test("parity error", e);

        e = errors;
        send_code(`KBD_EXT_CODE);
        send_code(8'h75);
        expect_display();
        send_code(`KBD_EXT_CODE);
        send_code(`KBD_BREAK_CODE);
        send_code(8'h75);
        expect_display();
        press_release(8'h4D);
        finish_test("extended keys", e);

        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/ps2_kbd_pkg.sv
hdl/ps2_rx.sv
hdl/kbd_ctrl.sv
hdl/key2ascii.sv
hdl/hex7seg.sv
hdl/kbd_display_top.sv
dv/tb_kbd_display.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the keyboard display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_kbd_display -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
